// ==== include/cart_loader_consts.svh ====
// Cartridge loader constants: header addresses, hotkeys, widths and gun defaults
`ifndef CART_LOADER_CONSTS_SVH
`define CART_LOADER_CONSTS_SVH

////////////////////
// Download bus
`define CL_ADDR_W 25
`define CL_DATA_W 16

// Index reserved for cheat code files
`define CL_CODE_INDEX 8'hFF

////////////////////
// Cartridge header
`define CL_HDR_REGION_A 'h1F0 // Region letters, both bytes
`define CL_HDR_REGION_B 'h1F2 // Extra region letter, low byte
`define CL_HDR_END 'h200

// Product code words, byte swapped on the bus
`define CL_ID_ADDR_0 'h182
`define CL_ID_ADDR_1 'h184
`define CL_ID_ADDR_2 'h186
`define CL_ID_ADDR_3 'h188
`define CL_ID_ADDR_4 'h18A
`define CL_ID_DONE 'h18C // First word past the code

////////////////////
// Region hotkey scan codes
`define CL_KEY_F1 9'h005
`define CL_KEY_F2 9'h006
`define CL_KEY_F3 9'h004

// Light gun sensor delay for titles not in the table
`define CL_GUN_DELAY_DEFAULT 8'd44

// One cheat record is this many 16-bit words
`define CL_CODE_WORDS 8

`endif

// ==== rtl/cart_loader_pkg.sv ====
// Cartridge loader types for regions, header flags, quirks and cheat records
package cart_loader_pkg;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// Automatic region source
	typedef enum logic [1:0] {
		MODE_INDEX  = 2'd0, // From file extension index
		MODE_HEADER = 2'd1,
		MODE_OFF    = 2'd2
	} region_mode_t;

	// Header priority order, first region wins
	typedef enum logic [1:0] {
		PRIO_UEJ = 2'd0, // US>EU>JP
		PRIO_EUJ = 2'd1, // EU>US>JP
		PRIO_UJE = 2'd2, // US>JP>EU
		PRIO_JUE = 2'd3  // JP>US>EU
	} region_prio_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} hdr_flags_t;

	typedef logic [63:0] cart_id_t; // Eight ASCII characters

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_t;

	// Fields are big endian, as the code files store them
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

// ==== rtl/header_capture.sv ====
// Header scanner that collects region letters and the product code from ROM writes
`include "cart_loader_consts.svh"

module header_capture (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          cart_download,
	input  logic                          cart_wr,
	input  logic [`CL_ADDR_W-1:0]         ioctl_addr,
	input  logic [`CL_DATA_W-1:0]         ioctl_data,
	output cart_loader_pkg::hdr_flags_t   hdr_flags,
	output logic                          hdr_ready,
	output cart_loader_pkg::cart_id_t     cart_id
);
	import cart_loader_pkg::*;

	logic       old_download;
	logic       dl_rise;
	logic       dl_fall;
	hdr_flags_t base_flags;
	hdr_flags_t lo_letter;
	hdr_flags_t hi_letter;
	hdr_flags_t region_a_flags;
	hdr_flags_t region_b_flags;
	logic       lo_hex;
	logic [3:0] hex_val;

	// J, U or E to its flag, anything else gives none
	function automatic hdr_flags_t letter_flags(input logic [7:0] ch);
		hdr_flags_t f;
		f = '0;
		case (ch)
			"J": f.j = 1'b1;
			"U": f.u = 1'b1;
			"E": f.e = 1'b1;
			default: ;
		endcase
		return f;
	endfunction

	assign dl_rise    = cart_download & ~old_download;
	assign dl_fall    = ~cart_download & old_download;
	assign base_flags = dl_rise ? hdr_flags_t'('0) : hdr_flags; // New cart starts clean

	assign lo_letter = letter_flags(ioctl_data[7:0]);
	assign hi_letter = letter_flags(ioctl_data[15:8]);

	////////////////////
	// Hex digit region code, bit 0 JP, bit 2 US, bit 3 EU
	always_comb begin
		lo_hex  = 1'b0;
		hex_val = ioctl_data[3:0];
		if (ioctl_data[7:0] >= "0" && ioctl_data[7:0] <= "9") begin
			lo_hex = 1'b1;
		end else if (ioctl_data[7:0] >= "A" && ioctl_data[7:0] <= "F") begin
			lo_hex  = 1'b1;
			hex_val = ioctl_data[3:0] + 4'd9; // 'A' has low nibble 1
		end
	end

	always_comb begin
		region_a_flags = base_flags;
		if (|lo_letter)
			region_a_flags = base_flags | lo_letter;
		else if (lo_hex)
			region_a_flags = '{j: hex_val[0], u: hex_val[2], e: hex_val[3]};
		region_a_flags = region_a_flags | hi_letter;
	end

	assign region_b_flags = base_flags | lo_letter;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			hdr_flags    <= '0;
			hdr_ready    <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (dl_rise) hdr_flags <= '0;
			if (dl_fall) hdr_ready <= 1'b0;
			if (cart_wr) begin
				if (ioctl_addr == `CL_HDR_REGION_A) hdr_flags <= region_a_flags;
				if (ioctl_addr == `CL_HDR_REGION_B) hdr_flags <= region_b_flags;
				if (ioctl_addr == `CL_HDR_END) hdr_ready <= 1'b1;
			end
		end
	end

	// Product code, first and last words carry one character each
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			if (ioctl_addr == `CL_ID_ADDR_0) cart_id[63:56] <= ioctl_data[15:8];
			if (ioctl_addr == `CL_ID_ADDR_1) cart_id[55:40] <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (ioctl_addr == `CL_ID_ADDR_2) cart_id[39:24] <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (ioctl_addr == `CL_ID_ADDR_3) cart_id[23:8] <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (ioctl_addr == `CL_ID_ADDR_4) cart_id[7:0] <= ioctl_data[7:0];
		end
	end

endmodule

// ==== rtl/region_select.sv ====
// Region chooser from header flags, download index or F1/F2/F3 hotkeys
`include "cart_loader_consts.svh"

module region_select (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  cart_loader_pkg::hdr_flags_t   hdr_flags,
	input  logic                          hdr_ready,
	input  cart_loader_pkg::region_mode_t region_mode,
	input  cart_loader_pkg::region_prio_t region_prio,
	input  logic [7:0]                    ioctl_index,
	input  logic [10:0]                   ps2_key,
	output cart_loader_pkg::region_t      region_req,
	output logic                          region_set
);
	import cart_loader_pkg::*;

	logic        old_ready;
	logic        ready_rise;
	logic        ready_fall;
	logic [10:0] key_q; // Input register for the keyboard bus
	logic        key_old;
	logic        key_event;

	function automatic logic has_flag(input hdr_flags_t f, input region_t r);
		case (r)
			REGION_JP: return f.j;
			REGION_US: return f.u;
			REGION_EU: return f.e;
			default:   return 1'b0;
		endcase
	endfunction

	// First present flag in priority order, else the order's first region
	function automatic region_t pick_region(input hdr_flags_t f, input region_prio_t p);
		region_t order [3];
		region_t pick;
		case (p)
			PRIO_UEJ: order = '{REGION_US, REGION_EU, REGION_JP};
			PRIO_EUJ: order = '{REGION_EU, REGION_US, REGION_JP};
			PRIO_UJE: order = '{REGION_US, REGION_JP, REGION_EU};
			default:  order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		pick = order[0];
		for (int i = 2; i >= 0; i--) begin
			if (has_flag(f, order[i])) pick = order[i];
		end
		return pick;
	endfunction

	assign ready_rise = hdr_ready & ~old_ready;
	assign ready_fall = ~hdr_ready & old_ready;
	assign key_event  = key_q[10] ^ key_old; // Bit 10 toggles per key

	always_ff @(posedge clk_sys) begin
		key_q   <= ps2_key;
		key_old <= key_q[10];
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_ready  <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			old_ready <= hdr_ready;
			if (key_event) begin
				case (key_q[8:0])
					`CL_KEY_F1: begin
						region_req <= REGION_JP;
						region_set <= key_q[9];
					end
					`CL_KEY_F2: begin
						region_req <= REGION_US;
						region_set <= key_q[9];
					end
					`CL_KEY_F3: begin
						region_req <= REGION_EU;
						region_set <= key_q[9];
					end
					default: ;
				endcase
			end
			if (ready_rise && region_mode == MODE_HEADER) begin
				region_req <= pick_region(hdr_flags, region_prio);
				region_set <= 1'b1;
			end else if (ready_rise && region_mode == MODE_INDEX) begin
				region_req <= region_t'(ioctl_index[7:6]);
				region_set <= |ioctl_index;
			end
			if (ready_fall) region_set <= 1'b0; // Release after the cart is in
		end
	end

endmodule

// ==== rtl/quirk_lookup.sv ====
// Per-title quirk flags and light gun settings looked up from the product code
`include "cart_loader_consts.svh"

module quirk_lookup (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      cart_download,
	input  logic                      cart_wr,
	input  logic [`CL_ADDR_W-1:0]     ioctl_addr,
	input  cart_loader_pkg::cart_id_t cart_id,
	output cart_loader_pkg::quirk_t   quirks,
	output logic                      gun_type,
	output logic [7:0]                gun_delay
);
	import cart_loader_pkg::*;

	logic   old_download;
	logic   id_done;
	quirk_t title_quirks;
	logic   title_gun_type;
	logic   [7:0] title_gun_delay;

	assign id_done = cart_wr && (ioctl_addr == `CL_ID_DONE);

	////////////////////
	// Quirk table
	always_comb begin
		title_quirks = '0;
		case (cart_id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				title_quirks.sram = 1'b1; // Odd SRAM mapping
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				title_quirks.eeprom = 1'b1;
			"T-113016": title_quirks.noram  = 1'b1; // Fake RAM check
			"T-89016 ": title_quirks.fifo   = 1'b1;
			"T-574023", "T-574013":
				title_quirks.pier = 1'b1;
			"MK-1229 ", "G-7001  ":
				title_quirks.svp = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-":
				title_quirks.fmbusy = 1'b1;
			default:
				// Compilation series, any three digits in the middle
				title_quirks.schan = (cart_id[63:32] == "T-68") && (cart_id[7:0] == "-");
		endcase
	end

	// Light gun titles with their own sensor timing
	always_comb begin
		title_gun_type  = 1'b0;
		title_gun_delay = `CL_GUN_DELAY_DEFAULT;
		case (cart_id)
			"MK-1533 ": title_gun_delay = 8'd100;
			"T-95096-": begin
				title_gun_type  = 1'b1; // Two-gun model
				title_gun_delay = 8'd52;
			end
			"T-95136-": begin
				title_gun_type  = 1'b1;
				title_gun_delay = 8'd30;
			end
			"MK-1658 ": title_gun_delay = 8'd120;
			"T-081156": title_gun_delay = 8'd126;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			quirks       <= '0;
			gun_type     <= 1'b0;
			gun_delay    <= `CL_GUN_DELAY_DEFAULT;
		end else begin
			old_download <= cart_download;
			if (cart_download & ~old_download) quirks <= '0;
			if (id_done) begin
				quirks    <= title_quirks;
				gun_type  <= title_gun_type;
				gun_delay <= title_gun_delay;
			end
		end
	end

endmodule

// ==== rtl/code_assembler.sv ====
// Cheat record builder from eight 16-bit code download words
`include "cart_loader_consts.svh"

module code_assembler (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         code_wr,
	input  logic [`CL_ADDR_W-1:0]        ioctl_addr,
	input  logic [`CL_DATA_W-1:0]        ioctl_data,
	output cart_loader_pkg::cheat_code_t code,
	output logic                         code_valid,
	output logic                         code_clear
);
	localparam int LAST_OFFSET = (`CL_CODE_WORDS - 1) * 2; // Byte offset of the last word

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  code.flags[15:0]    <= ioctl_data;
				4'd2:  code.flags[31:16]   <= ioctl_data;
				4'd4:  code.address[15:0]  <= ioctl_data;
				4'd6:  code.address[31:16] <= ioctl_data;
				4'd8:  code.compare[15:0]  <= ioctl_data;
				4'd10: code.compare[31:16] <= ioctl_data;
				4'd12: code.replace[15:0]  <= ioctl_data;
				4'd14: code.replace[31:16] <= ioctl_data;
				default: ;
			endcase
		end
	end

	////////////////////
	// Strobes
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			code_valid <= code_wr && (ioctl_addr[3:0] == 4'(LAST_OFFSET)); // Record complete
			code_clear <= code_wr && (ioctl_addr == '0); // New code file starts
		end
	end

endmodule

// ==== rtl/rom_write_pacer.sv ====
// ROM write pacing with toggle handshake to both memory ports and ROM size capture
`include "cart_loader_consts.svh"

module rom_write_pacer (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  cart_download,
	input  logic                  cart_wr,
	input  logic [`CL_ADDR_W-1:0] ioctl_addr,
	input  logic                  sd_wrack,
	input  logic                  dd_wrack,
	output logic                  rom_wr,
	output logic                  ioctl_wait,
	output logic [`CL_ADDR_W-1:0] rom_sz
);
	logic old_download;
	logic acks_done;

	// Both ports have caught up with the request toggle
	assign acks_done = (sd_wrack == rom_wr) && (dd_wrack == rom_wr);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			rom_wr       <= 1'b0;
			ioctl_wait   <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (cart_wr) begin
				rom_wr     <= ~rom_wr; // One toggle per word
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && acks_done) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Last address seen when the download ends
	always_ff @(posedge clk_sys) begin
		if (old_download & ~cart_download) rom_sz <= ioctl_addr;
	end

endmodule

// ==== rtl/cart_loader_top.sv ====
// Cartridge loader top level that splits the download stream and wires the blocks
`include "cart_loader_consts.svh"

module cart_loader_top (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          ioctl_download,
	input  logic [7:0]                    ioctl_index,
	input  logic                          ioctl_wr,
	input  logic [`CL_ADDR_W-1:0]         ioctl_addr,
	input  logic [`CL_DATA_W-1:0]         ioctl_data,
	input  logic [10:0]                   ps2_key,
	input  cart_loader_pkg::region_mode_t region_mode,
	input  cart_loader_pkg::region_prio_t region_prio,
	input  logic                          sd_wrack,
	input  logic                          dd_wrack,
	output logic                          ioctl_wait,
	output logic                          rom_wr,
	output logic [`CL_ADDR_W-1:0]         rom_sz,
	output cart_loader_pkg::region_t      region_req,
	output logic                          region_set,
	output cart_loader_pkg::quirk_t       quirks,
	output logic                          gun_type,
	output logic [7:0]                    gun_delay,
	output cart_loader_pkg::cheat_code_t  code,
	output logic                          code_valid,
	output logic                          code_clear
);
	import cart_loader_pkg::*;

	logic       code_index;
	logic       cart_download;
	logic       cart_wr;
	logic       code_wr;
	hdr_flags_t hdr_flags;
	logic       hdr_ready;
	cart_id_t   cart_id;

	////////////////////
	// Download split
	assign code_index    = (ioctl_index == `CL_CODE_INDEX);
	assign cart_download = ioctl_download & ~code_index;
	assign cart_wr       = cart_download & ioctl_wr;
	assign code_wr       = ioctl_download & code_index & ioctl_wr;

	header_capture u_header_capture (
		.clk_sys, .RESET, .cart_download, .cart_wr, .ioctl_addr, .ioctl_data,
		.hdr_flags, .hdr_ready, .cart_id
	);

	region_select u_region_select (
		.clk_sys, .RESET, .hdr_flags, .hdr_ready, .region_mode, .region_prio,
		.ioctl_index, .ps2_key, .region_req, .region_set
	);

	quirk_lookup u_quirk_lookup (
		.clk_sys, .RESET, .cart_download, .cart_wr, .ioctl_addr, .cart_id,
		.quirks, .gun_type, .gun_delay
	);

	code_assembler u_code_assembler (
		.clk_sys, .RESET, .code_wr, .ioctl_addr, .ioctl_data,
		.code, .code_valid, .code_clear
	);

	// ROM side, both memory ports take every cart word
	rom_write_pacer u_rom_write_pacer (
		.clk_sys, .RESET, .cart_download, .cart_wr, .ioctl_addr,
		.sd_wrack, .dd_wrack, .rom_wr, .ioctl_wait, .rom_sz
	);

endmodule

// ==== tests/cart_loader_props.sv ====
// Bound checks on ROM write pacing, header region choice and cheat record strobes
module cart_loader_props (
	input logic                          clk_sys,
	input logic                          RESET,
	input logic                          cart_wr,
	input logic                          ioctl_wait,
	input logic                          rom_wr,
	input logic                          sd_wrack,
	input logic                          dd_wrack,
	input logic                          code_valid,
	input logic                          code_clear,
	input logic                          hdr_ready,
	input cart_loader_pkg::hdr_flags_t   hdr_flags,
	input cart_loader_pkg::region_mode_t region_mode,
	input cart_loader_pkg::region_prio_t region_prio,
	input cart_loader_pkg::region_t      region_req
);
	import cart_loader_pkg::*;

	int unsigned fail_count = 0;
	region_t     header_pick;

	// Header rule spelled out per order, first region when no flag is set
	always_comb begin
		case (region_prio)
			PRIO_UEJ: header_pick = hdr_flags.u ? REGION_US : hdr_flags.e ? REGION_EU :
				hdr_flags.j ? REGION_JP : REGION_US;
			PRIO_EUJ: header_pick = hdr_flags.e ? REGION_EU : hdr_flags.u ? REGION_US :
				hdr_flags.j ? REGION_JP : REGION_EU;
			PRIO_UJE: header_pick = hdr_flags.u ? REGION_US : hdr_flags.j ? REGION_JP :
				hdr_flags.e ? REGION_EU : REGION_US;
			default: header_pick = hdr_flags.j ? REGION_JP : hdr_flags.u ? REGION_US :
				hdr_flags.e ? REGION_EU : REGION_JP;
		endcase
	end

	////////////////////
	// ROM write handshake
	wait_release: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(ioctl_wait) |-> $past(sd_wrack == rom_wr && dd_wrack == rom_wr))
	else begin
		$error("ioctl_wait dropped before both memory ports acknowledged");
		fail_count++;
	end

	write_toggle: assert property (@(posedge clk_sys) disable iff (RESET)
		(rom_wr ^ $past(rom_wr)) == $past(cart_wr)) // One toggle per cart word
	else begin
		$error("rom_wr toggle does not match the cart write strobe");
		fail_count++;
	end

	////////////////////
	// Record strobes
	valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
	else begin
		$error("code_valid stayed high for more than one cycle");
		fail_count++;
	end

	clear_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_clear |=> !code_clear)
	else begin
		$error("code_clear stayed high for more than one cycle");
		fail_count++;
	end

	header_region: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(hdr_ready) && region_mode == MODE_HEADER |=> region_req == $past(header_pick))
	else begin
		$error("region_req does not follow the header priority rule");
		fail_count++;
	end

endmodule

// ==== tests/cart_loader_tb.sv ====
// Testbench for the cartridge loader with memory acknowledge models and hotkey events
`include "cart_loader_consts.svh"

module cart_loader_tb;
	import cart_loader_pkg::*;

	// Six downloads of at most 265 words, 12 cycles per word worst case, plus reset
	localparam int TIMEOUT_CYCLES = 6 * 265 * 12 + 920;
	localparam logic [`CL_ADDR_W-1:0] CART_BYTES = 'h210;

	logic                  clk_sys;
	logic                  RESET;
	logic                  ioctl_download;
	logic [7:0]            ioctl_index;
	logic                  ioctl_wr;
	logic [`CL_ADDR_W-1:0] ioctl_addr;
	logic [`CL_DATA_W-1:0] ioctl_data;
	logic [10:0]           ps2_key;
	region_mode_t          region_mode;
	region_prio_t          region_prio;
	logic                  sd_wrack;
	logic                  dd_wrack;
	logic                  ioctl_wait;
	logic                  rom_wr;
	logic [`CL_ADDR_W-1:0] rom_sz;
	region_t               region_req;
	logic                  region_set;
	quirk_t                quirks;
	logic                  gun_type;
	logic [7:0]            gun_delay;
	cheat_code_t           code;
	logic                  code_valid;
	logic                  code_clear;

	logic [31:0] lfsr = 32'd98076;
	logic        rom_wr_seen = 1'b0;
	int          cycle_count = 0;
	int          toggle_count = 0;
	int          valid_count = 0;
	int          clear_count = 0;
	int          mark_toggles;
	int          mark_valid;
	int          mark_clear;
	int          test_count = 0;
	int          test_errors = 0;
	int          error_count = 0;
	string       test_name;
	logic [7:0]  img_a_lo; // Header bytes of the image being loaded
	logic [7:0]  img_a_hi;
	logic [7:0]  img_b_lo;
	cart_id_t    img_id;
	cheat_code_t cheat;

	cart_loader_top dut (.*);

	bind cart_loader_top cart_loader_props props (
		.clk_sys, .RESET, .cart_wr, .ioctl_wait, .rom_wr, .sd_wrack, .dd_wrack,
		.code_valid, .code_clear, .hdr_ready, .hdr_flags, .region_mode, .region_prio,
		.region_req
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Galois LFSR, one step per bit
	function automatic logic lfsr_bit();
		logic out;
		out  = lfsr[0];
		lfsr = (lfsr >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
		return out;
	endfunction

	function automatic int ack_delay();
		logic [2:0] v;
		for (int i = 0; i < 3; i++) v[i] = lfsr_bit();
		return int'(v) + 1; // 1 to 8 cycles
	endfunction

	////////////////////
	// Memory port models
	initial begin
		sd_wrack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_wrack != rom_wr) begin
				repeat (ack_delay() - 1) @(negedge clk_sys);
				sd_wrack = rom_wr;
			end
		end
	end

	initial begin
		dd_wrack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (dd_wrack != rom_wr) begin
				repeat (ack_delay() - 1) @(negedge clk_sys);
				dd_wrack = rom_wr;
			end
		end
	end

	// Event counters and the run limit
	always @(negedge clk_sys) begin
		rom_wr_seen <= rom_wr;
		cycle_count <= cycle_count + 1;
		if (!RESET && rom_wr != rom_wr_seen) toggle_count <= toggle_count + 1;
		if (!RESET && code_valid) valid_count <= valid_count + 1;
		if (!RESET && code_clear) clear_count <= clear_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [127:0] expected,
			input logic [127:0] actual);
		assert (actual === expected) else begin
			$display("FAIL %s %s expected %0h actual %0h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic close_test();
		test_count++;
		error_count += test_errors;
		if (test_errors == 0)
			$display("%-10s ok", test_name);
		else
			$display("%-10s %0d mismatches", test_name, test_errors);
	endtask

	////////////////////
	// Download bus
	task automatic write_word(input logic [`CL_ADDR_W-1:0] addr, input logic [15:0] data);
		while (ioctl_wait) @(negedge clk_sys);
		ioctl_addr = addr;
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	// Product code at 0x183, region letters at 0x1F0, fill from the whole address
	function automatic logic [7:0] rom_byte(input logic [`CL_ADDR_W-1:0] a);
		if (a >= 'h183 && a <= 'h18A) return 8'(img_id >> (8 * ('h18A - a)));
		if (a == 'h1F0) return img_a_lo;
		if (a == 'h1F1) return img_a_hi;
		if (a == 'h1F2) return img_b_lo;
		return 8'(a ^ (a >> 8) ^ (a >> 16));
	endfunction

	task automatic load_cart(input logic [7:0] index, input region_mode_t mode,
			input region_prio_t prio, input logic [7:0] a_lo, input logic [7:0] a_hi,
			input cart_id_t id);
		logic [`CL_ADDR_W-1:0] a;
		img_a_lo       = a_lo;
		img_a_hi       = a_hi;
		img_id         = id;
		ioctl_index    = index;
		region_mode    = mode;
		region_prio    = prio;
		ioctl_download = 1'b1;
		for (a = '0; a < CART_BYTES; a = a + 2'd2)
			write_word(a, {rom_byte(a + 1'b1), rom_byte(a)}); // Low byte is the even address
		while (ioctl_wait) @(negedge clk_sys);
	endtask

	// Words go low half then high half through flags, address, compare, replace
	task automatic load_codes(input cheat_code_t rec);
		logic [`CL_ADDR_W-1:0] off;
		ioctl_index    = `CL_CODE_INDEX;
		ioctl_download = 1'b1;
		for (off = '0; off < 2 * `CL_CODE_WORDS; off = off + 2'd2)
			write_word(off, 16'(rec >> (96 - 32 * off[3:2] + 16 * off[1])));
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic send_key(input logic press, input logic [8:0] scan);
		ps2_key = {~ps2_key[10], press, scan};
		repeat (3) @(negedge clk_sys);
	endtask

	initial begin
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		ps2_key        = '0;
		region_mode    = MODE_HEADER;
		region_prio    = PRIO_UEJ;
		img_b_lo       = " ";
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;

		begin_test("pacing");
		mark_toggles = toggle_count;
		load_cart(8'h01, MODE_HEADER, PRIO_UEJ, "U", " ", "T-89016 ");
		check_value("toggles", 128'(CART_BYTES / 2), 128'(toggle_count - mark_toggles));
		// Toggle level from reset follows the parity of the word count
		check_value("acks", 128'({3{CART_BYTES[1]}}), 128'({rom_wr, sd_wrack, dd_wrack}));
		check_value("region", 128'(REGION_US), 128'(region_req));
		check_value("set", 128'(1'b1), 128'(region_set));
		check_value("quirks", 128'(8'b0010_0000), 128'(quirks)); // fifo only
		end_download();
		check_value("wait", 128'(1'b0), 128'(ioctl_wait));
		check_value("rom_sz", 128'(CART_BYTES - 2'd2), 128'(rom_sz));
		close_test();

		begin_test("hex_digit");
		load_cart(8'h01, MODE_HEADER, PRIO_UEJ, "A", " ", "T-95096-");
		check_value("flags", 128'(3'b001), 128'(dut.hdr_flags)); // 'A' is 1010, e only
		check_value("region", 128'(REGION_EU), 128'(region_req));
		check_value("gun_type", 128'(1'b1), 128'(gun_type));
		check_value("gun_delay", 128'(8'd52), 128'(gun_delay));
		end_download();
		close_test();

		begin_test("prio_jue");
		load_cart(8'h01, MODE_HEADER, PRIO_JUE, "J", "E", "ABCDEFGH");
		check_value("region", 128'(REGION_JP), 128'(region_req));
		check_value("quirks", 128'(8'h00), 128'(quirks));
		check_value("gun", 128'({1'b0, 8'd44}), 128'({gun_type, gun_delay}));
		end_download();
		close_test();

		begin_test("prio_euj");
		load_cart(8'h01, MODE_HEADER, PRIO_EUJ, " ", " ", "ABCDEFGH");
		check_value("region", 128'(REGION_EU), 128'(region_req)); // No flag, order's first
		end_download();
		close_test();

		begin_test("index");
		load_cart(8'h80, MODE_INDEX, PRIO_UEJ, "J", " ", "ABCDEFGH");
		check_value("region", 128'(REGION_EU), 128'(region_req));
		check_value("set", 128'(1'b1), 128'(region_set));
		end_download();
		check_value("released", 128'(1'b0), 128'(region_set));
		close_test();

		////////////////////
		// Cheat record and hotkeys
		begin_test("cheat");
		cheat      = '{flags: 32'h0000_0001, address: 32'h00FF_1234,
			compare: 32'h0000_ABCD, replace: 32'h1234_5678};
		mark_valid = valid_count;
		mark_clear = clear_count;
		load_codes(cheat);
		check_value("code", cheat, code);
		check_value("valid", 128'(1), 128'(valid_count - mark_valid));
		check_value("clear", 128'(1), 128'(clear_count - mark_clear));
		end_download();
		close_test();

		begin_test("hotkey");
		send_key(1'b1, `CL_KEY_F2);
		check_value("region", 128'(REGION_US), 128'(region_req));
		check_value("set", 128'(1'b1), 128'(region_set));
		send_key(1'b0, `CL_KEY_F2);
		check_value("release", 128'(1'b0), 128'(region_set));
		close_test();

		$display("%0d tests, %0d value mismatches, %0d assertion failures",
			test_count, error_count, dut.props.fail_count);
		if (error_count == 0 && dut.props.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== cart_loader.f ====
+incdir+include
rtl/cart_loader_pkg.sv
rtl/header_capture.sv
rtl/region_select.sv
rtl/quirk_lookup.sv
rtl/code_assembler.sv
rtl/rom_write_pacer.sv
rtl/cart_loader_top.sv
tests/cart_loader_props.sv
tests/cart_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f cart_loader.f \
	--top-module cart_loader_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep running past the first assertion error so the testbench reaches its verdict
output=$(./obj_dir/Vcart_loader_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
